/* logic/des_pkg.sv */
package des_pkg;

	localparam int block_width = 64;
	localparam int half_width = 32;
	localparam int subkey_width = 48;
	localparam int cd_width = 28;
	localparam int max_rounds = 16;

	// the same 64 bits seen as one word or as the two Feistel halves
	typedef union packed {
		logic [block_width-1:0] block;
		struct packed {
			logic [half_width-1:0] left;
			logic [half_width-1:0] right;
		} halves;
	} des_block_u;

	// table entries are one-based FIPS bit numbers where bit 1 is the msb
	// the first entry listed lands in the highest index
	localparam logic [block_width-1:0][6:0] ip_table = {
		7'd58, 7'd50, 7'd42, 7'd34, 7'd26, 7'd18, 7'd10, 7'd2,
		7'd60, 7'd52, 7'd44, 7'd36, 7'd28, 7'd20, 7'd12, 7'd4,
		7'd62, 7'd54, 7'd46, 7'd38, 7'd30, 7'd22, 7'd14, 7'd6,
		7'd64, 7'd56, 7'd48, 7'd40, 7'd32, 7'd24, 7'd16, 7'd8,
		7'd57, 7'd49, 7'd41, 7'd33, 7'd25, 7'd17, 7'd9, 7'd1,
		7'd59, 7'd51, 7'd43, 7'd35, 7'd27, 7'd19, 7'd11, 7'd3,
		7'd61, 7'd53, 7'd45, 7'd37, 7'd29, 7'd21, 7'd13, 7'd5,
		7'd63, 7'd55, 7'd47, 7'd39, 7'd31, 7'd23, 7'd15, 7'd7
	};

	localparam logic [block_width-1:0][6:0] fp_table = {
		7'd40, 7'd8, 7'd48, 7'd16, 7'd56, 7'd24, 7'd64, 7'd32,
		7'd39, 7'd7, 7'd47, 7'd15, 7'd55, 7'd23, 7'd63, 7'd31,
		7'd38, 7'd6, 7'd46, 7'd14, 7'd54, 7'd22, 7'd62, 7'd30,
		7'd37, 7'd5, 7'd45, 7'd13, 7'd53, 7'd21, 7'd61, 7'd29,
		7'd36, 7'd4, 7'd44, 7'd12, 7'd52, 7'd20, 7'd60, 7'd28,
		7'd35, 7'd3, 7'd43, 7'd11, 7'd51, 7'd19, 7'd59, 7'd27,
		7'd34, 7'd2, 7'd42, 7'd10, 7'd50, 7'd18, 7'd58, 7'd26,
		7'd33, 7'd1, 7'd41, 7'd9, 7'd49, 7'd17, 7'd57, 7'd25
	};

	localparam logic [subkey_width-1:0][6:0] e_table = {
		7'd32, 7'd1, 7'd2, 7'd3, 7'd4, 7'd5,
		7'd4, 7'd5, 7'd6, 7'd7, 7'd8, 7'd9,
		7'd8, 7'd9, 7'd10, 7'd11, 7'd12, 7'd13,
		7'd12, 7'd13, 7'd14, 7'd15, 7'd16, 7'd17,
		7'd16, 7'd17, 7'd18, 7'd19, 7'd20, 7'd21,
		7'd20, 7'd21, 7'd22, 7'd23, 7'd24, 7'd25,
		7'd24, 7'd25, 7'd26, 7'd27, 7'd28, 7'd29,
		7'd28, 7'd29, 7'd30, 7'd31, 7'd32, 7'd1
	};

	localparam logic [half_width-1:0][6:0] p_table = {
		7'd16, 7'd7, 7'd20, 7'd21, 7'd29, 7'd12, 7'd28, 7'd17,
		7'd1, 7'd15, 7'd23, 7'd26, 7'd5, 7'd18, 7'd31, 7'd10,
		7'd2, 7'd8, 7'd24, 7'd14, 7'd32, 7'd27, 7'd3, 7'd9,
		7'd19, 7'd13, 7'd30, 7'd6, 7'd22, 7'd11, 7'd4, 7'd25
	};

	// the parity bits 8, 16, ..., 64 are dropped here
	localparam logic [2*cd_width-1:0][6:0] pc1_table = {
		7'd57, 7'd49, 7'd41, 7'd33, 7'd25, 7'd17, 7'd9,
		7'd1, 7'd58, 7'd50, 7'd42, 7'd34, 7'd26, 7'd18,
		7'd10, 7'd2, 7'd59, 7'd51, 7'd43, 7'd35, 7'd27,
		7'd19, 7'd11, 7'd3, 7'd60, 7'd52, 7'd44, 7'd36,
		7'd63, 7'd55, 7'd47, 7'd39, 7'd31, 7'd23, 7'd15,
		7'd7, 7'd62, 7'd54, 7'd46, 7'd38, 7'd30, 7'd22,
		7'd14, 7'd6, 7'd61, 7'd53, 7'd45, 7'd37, 7'd29,
		7'd21, 7'd13, 7'd5, 7'd28, 7'd20, 7'd12, 7'd4
	};

	localparam logic [subkey_width-1:0][6:0] pc2_table = {
		7'd14, 7'd17, 7'd11, 7'd24, 7'd1, 7'd5,
		7'd3, 7'd28, 7'd15, 7'd6, 7'd21, 7'd10,
		7'd23, 7'd19, 7'd12, 7'd4, 7'd26, 7'd8,
		7'd16, 7'd7, 7'd27, 7'd20, 7'd13, 7'd2,
		7'd41, 7'd52, 7'd31, 7'd37, 7'd47, 7'd55,
		7'd30, 7'd40, 7'd51, 7'd45, 7'd33, 7'd48,
		7'd44, 7'd49, 7'd39, 7'd56, 7'd34, 7'd53,
		7'd46, 7'd42, 7'd50, 7'd36, 7'd29, 7'd32
	};

	localparam int shift_schedule [max_rounds] = '{
		1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
	};

	// each box is stored row after row, so the index is {row, column}
	localparam logic [3:0] sbox_table [8][64] = '{
		'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
		  0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
		  4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
		  15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
		'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
		  3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
		  0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
		  13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
		'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
		  13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
		  13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
		  1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
		'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
		  13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
		  10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
		  3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
		'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
		  14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
		  4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
		  11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
		'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
		  10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
		  9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
		  4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
		'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
		  13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
		  1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
		  6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
		'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
		  1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
		  7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
		  2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
	};

	// narrower tables and vectors arrive zero extended on the msb side,
	// so entry i of an n entry table sits at index n-1-i
	function automatic logic [block_width-1:0] permute(
		input logic [block_width-1:0] data,
		input int in_width,
		input logic [block_width-1:0][6:0] tbl,
		input int out_width
	);
		logic [block_width-1:0] result;
		result = '0;
		for (int i = 0; i < out_width; i++) begin
			result[out_width-1-i] = data[in_width - int'(tbl[out_width-1-i])];
		end
		return result;
	endfunction

	function automatic logic [half_width-1:0] sbox_lookup(input logic [subkey_width-1:0] x);
		logic [half_width-1:0] y;
		logic [5:0] chunk;
		for (int b = 0; b < 8; b++) begin
			chunk = x[subkey_width-1-6*b -: 6];
			// outer bits pick the row, inner four bits the column
			y[half_width-1-4*b -: 4] = sbox_table[b][{chunk[5], chunk[0], chunk[4:1]}];
		end
		return y;
	endfunction

endpackage

/* logic/des_input_stage.sv */
`timescale 1ns/10ps

module des_input_stage (
	input  logic clock,
	input  logic rst,
	input  logic [des_pkg::block_width-1:0] plaintext,
	input  logic iv,
	output des_pkg::des_block_u state_block,
	output logic state_valid
);

	logic [des_pkg::block_width-1:0] input_reg;
	logic input_valid;
	des_pkg::des_block_u ip_block;

	// raw plaintext is captured first, ahead of the initial permutation
	always_ff @(posedge clock) begin
		if (rst) begin
			input_reg <= '0;
			input_valid <= 1'b0;
		end else begin
			input_reg <= plaintext;
			input_valid <= iv;
		end
	end

	assign ip_block.block = des_pkg::permute(input_reg, des_pkg::block_width,
		des_pkg::ip_table, des_pkg::block_width);

	always_ff @(posedge clock) begin
		if (rst) begin
			state_block.block <= '0;
			state_valid <= 1'b0;
		end else begin
			state_block <= ip_block;
			state_valid <= input_valid;
		end
	end

	a_plaintext_known: assert property (@(posedge clock) disable iff (rst)
		iv |-> !$isunknown(plaintext));

endmodule

/* logic/des_key_schedule.sv */
`timescale 1ns/10ps

module des_key_schedule #(
	parameter int num_rounds = 16
) (
	input  logic [des_pkg::block_width-1:0] key,
	output logic [num_rounds*des_pkg::subkey_width-1:0] round_keys
);

	localparam int cd_pair_width = 2 * des_pkg::cd_width;

	logic [cd_pair_width-1:0] pc1_out;
	logic [des_pkg::cd_width-1:0] c [0:num_rounds];
	logic [des_pkg::cd_width-1:0] d [0:num_rounds];

	if (num_rounds < 1 || num_rounds > des_pkg::max_rounds) begin : g_bad_rounds
		$error("num_rounds must lie between 1 and %0d", des_pkg::max_rounds);
	end

	assign pc1_out = cd_pair_width'(des_pkg::permute(key, des_pkg::block_width,
		des_pkg::pc1_table, cd_pair_width));
	assign {c[0], d[0]} = pc1_out;

	// each round rotates both halves from the previous round's value
	for (genvar r = 0; r < num_rounds; r++) begin : g_round_key
		localparam int shift = des_pkg::shift_schedule[r];

		assign c[r+1] = (c[r] << shift) | (c[r] >> (des_pkg::cd_width - shift));
		assign d[r+1] = (d[r] << shift) | (d[r] >> (des_pkg::cd_width - shift));

		// key 1 sits in the lowest slice
		assign round_keys[r*des_pkg::subkey_width +: des_pkg::subkey_width] =
			des_pkg::subkey_width'(des_pkg::permute(
				des_pkg::block_width'({c[r+1], d[r+1]}), cd_pair_width,
				des_pkg::pc2_table, des_pkg::subkey_width));
	end

endmodule

/* logic/des_round.sv */
`timescale 1ns/10ps

module des_round (
	input  logic clock,
	input  logic rst,
	input  des_pkg::des_block_u in_block,
	input  logic in_valid,
	input  logic [des_pkg::subkey_width-1:0] subkey,
	output des_pkg::des_block_u out_block,
	output logic out_valid
);

	logic [des_pkg::subkey_width-1:0] expanded;
	logic [des_pkg::subkey_width-1:0] mixed;
	logic [des_pkg::half_width-1:0] sbox_out;
	logic [des_pkg::half_width-1:0] f_out;

	// f function of the right half
	assign expanded = des_pkg::subkey_width'(des_pkg::permute(
		des_pkg::block_width'(in_block.halves.right), des_pkg::half_width,
		des_pkg::e_table, des_pkg::subkey_width));

	assign mixed = expanded ^ subkey;
	assign sbox_out = des_pkg::sbox_lookup(mixed);

	assign f_out = des_pkg::half_width'(des_pkg::permute(
		des_pkg::block_width'(sbox_out), des_pkg::half_width,
		des_pkg::p_table, des_pkg::half_width));

	// the old right half becomes the new left half
	always_ff @(posedge clock) begin
		if (rst) begin
			out_block.block <= '0;
			out_valid <= 1'b0;
		end else begin
			out_block.halves.left <= in_block.halves.right;
			out_block.halves.right <= in_block.halves.left ^ f_out;
			out_valid <= in_valid;
		end
	end

endmodule

/* logic/des_round_pipeline.sv */
`timescale 1ns/10ps

module des_round_pipeline #(
	parameter int num_rounds = 16
) (
	input  logic clock,
	input  logic rst,
	input  des_pkg::des_block_u state_block,
	input  logic state_valid,
	input  logic [num_rounds*des_pkg::subkey_width-1:0] round_keys,
	output des_pkg::des_block_u preoutput_block,
	output logic preoutput_valid
);

	// stage 0 is the input of round 1, stage i the output of round i
	des_pkg::des_block_u stage_block [0:num_rounds];
	logic [num_rounds:0] stage_valid;

	assign stage_block[0] = state_block;
	assign stage_valid[0] = state_valid;

	for (genvar i = 0; i < num_rounds; i++) begin : g_round
		des_round i_round (
			.clock(clock),
			.rst(rst),
			.in_block(stage_block[i]),
			.in_valid(stage_valid[i]),
			.subkey(round_keys[i*des_pkg::subkey_width +: des_pkg::subkey_width]),
			.out_block(stage_block[i+1]),
			.out_valid(stage_valid[i+1])
		);
	end

	assign preoutput_block = stage_block[num_rounds];
	assign preoutput_valid = stage_valid[num_rounds];

	// subkeys are not pipelined, so a block in flight needs a steady key
	a_key_stable: assert property (@(posedge clock) disable iff (rst)
		(|stage_valid) |-> $stable(round_keys));

endmodule

/* logic/des_output_stage.sv */
`timescale 1ns/10ps

module des_output_stage (
	input  logic clock,
	input  logic rst,
	input  des_pkg::des_block_u preoutput_block,
	input  logic preoutput_valid,
	output logic [des_pkg::block_width-1:0] ciphertext,
	output logic ov
);

	logic [des_pkg::block_width-1:0] swapped;
	logic [des_pkg::block_width-1:0] final_block;

	// the last round is undone by swapping the halves back to R16 || L16
	assign swapped = {preoutput_block.halves.right, preoutput_block.halves.left};
	assign final_block = des_pkg::permute(swapped, des_pkg::block_width,
		des_pkg::fp_table, des_pkg::block_width);

	always_ff @(posedge clock) begin
		if (rst) begin
			ciphertext <= '0;
			ov <= 1'b0;
		end else begin
			ciphertext <= final_block;
			ov <= preoutput_valid;
		end
	end

	a_ov_known: assert property (@(posedge clock) disable iff (rst) !$isunknown(ov));

endmodule

/* logic/des.sv */
`timescale 1ns/10ps

module des #(
	parameter int num_rounds = 16
) (
	input  logic clock,
	input  logic rst,
	input  logic [des_pkg::block_width-1:0] key,
	input  logic [des_pkg::block_width-1:0] plaintext,
	input  logic iv,
	output logic [des_pkg::block_width-1:0] ciphertext,
	output logic ov
);

	des_pkg::des_block_u state_block;
	des_pkg::des_block_u preoutput_block;
	logic state_valid;
	logic preoutput_valid;
	logic [num_rounds*des_pkg::subkey_width-1:0] round_keys;

	des_input_stage i_input_stage (
		.clock(clock),
		.rst(rst),
		.plaintext(plaintext),
		.iv(iv),
		.state_block(state_block),
		.state_valid(state_valid)
	);

	// the key schedule is combinational and shared by every round
	des_key_schedule #(
		.num_rounds(num_rounds)
	) i_key_schedule (
		.key(key),
		.round_keys(round_keys)
	);

	des_round_pipeline #(
		.num_rounds(num_rounds)
	) i_round_pipeline (
		.clock(clock),
		.rst(rst),
		.state_block(state_block),
		.state_valid(state_valid),
		.round_keys(round_keys),
		.preoutput_block(preoutput_block),
		.preoutput_valid(preoutput_valid)
	);

	des_output_stage i_output_stage (
		.clock(clock),
		.rst(rst),
		.preoutput_block(preoutput_block),
		.preoutput_valid(preoutput_valid),
		.ciphertext(ciphertext),
		.ov(ov)
	);

endmodule

/* tb/des_tb.sv */
`timescale 1ns/10ps

module des_tb;

	localparam int latency = des_pkg::max_rounds + 3;
	localparam int n_burst = 40;
	localparam int n_gapped = 64;
	localparam int n_keys = 3;
	localparam int n_per_key = 16;
	localparam int n_reset = 10;
	localparam int n_drains = 7;
	localparam int n_stimulus = 1 + n_burst + n_gapped + n_keys * n_per_key + 2 * n_reset;
	// every drain waits out one full pipeline latency
	localparam int watchdog_cycles = n_stimulus + latency * n_drains + 50;

	localparam logic [63:0] kat_key = 64'h1334_5779_9bbc_dff1;
	localparam logic [63:0] kat_pt = 64'h0123_4567_89ab_cdef;
	localparam logic [63:0] kat_ct = 64'h85e8_1354_0f0a_b405;

	logic clock = 1'b0;
	logic rst = 1'b1;
	logic [63:0] key = '0;
	logic [63:0] plaintext = '0;
	logic iv = 1'b0;
	logic [63:0] ciphertext;
	logic ov;

	integer seed = 32'h387e_6d63;
	int cycle = 0;
	int iv_count = 0;
	int ov_count = 0;
	logic [63:0] exp_data [$];
	int exp_cycle [$];

	des i_dut (
		.clock(clock),
		.rst(rst),
		.key(key),
		.plaintext(plaintext),
		.iv(iv),
		.ciphertext(ciphertext),
		.ov(ov)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// software DES, one bit at a time from the FIPS tables
	function automatic logic [63:0] des_encrypt(input logic [63:0] k, input logic [63:0] pt);
		logic [55:0] cd;
		logic [47:0] e;
		logic [31:0] l;
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] f;
		logic [63:0] blk;
		logic [63:0] ct;
		logic [5:0] six;
		for (int j = 0; j < 56; j++) begin
			cd[55-j] = k[64 - des_pkg::pc1_table[55-j]];
		end
		for (int j = 0; j < 64; j++) begin
			blk[63-j] = pt[64 - des_pkg::ip_table[63-j]];
		end
		l = blk[63:32];
		r = blk[31:0];
		for (int n = 0; n < des_pkg::max_rounds; n++) begin
			// C and D each rotate left by one bit per step
			for (int m = 0; m < des_pkg::shift_schedule[n]; m++) begin
				cd = {cd[54:28], cd[55], cd[26:0], cd[27]};
			end
			// expansion of R mixed with the PC-2 subkey
			for (int j = 0; j < 48; j++) begin
				e[47-j] = r[32 - des_pkg::e_table[47-j]] ^ cd[56 - des_pkg::pc2_table[47-j]];
			end
			for (int b = 0; b < 8; b++) begin
				six = e[47-6*b -: 6];
				s[31-4*b -: 4] = des_pkg::sbox_table[b][{six[5], six[0], six[4:1]}];
			end
			for (int j = 0; j < 32; j++) begin
				f[31-j] = s[32 - des_pkg::p_table[31-j]];
			end
			{l, r} = {r, l ^ f};
		end
		blk = {r, l};
		for (int j = 0; j < 64; j++) begin
			ct[63-j] = blk[64 - des_pkg::fp_table[63-j]];
		end
		return ct;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			stop_on_error($sformatf("%s is wrong at cycle %0d", name, cycle));
		end
	endtask

	// a block driven after edge m is captured at m+1 and leaves at edge m + latency
	task automatic send_block(input logic [63:0] pt, input logic [63:0] expected);
		@(posedge clock);
		#1;
		plaintext = pt;
		iv = 1'b1;
		exp_data.push_back(expected);
		exp_cycle.push_back(cycle + latency);
		iv_count++;
	endtask

	task automatic send_random();
		logic [63:0] pt;
		pt = {$random(seed), $random(seed)};
		send_block(pt, des_encrypt(key, pt));
	endtask

	task automatic idle();
		@(posedge clock);
		#1;
		iv = 1'b0;
		plaintext = {$random(seed), $random(seed)};
	endtask

	// the last block sent has left the pipeline one latency after the idle edge
	task automatic drain();
		idle();
		repeat (latency) @(posedge clock);
		#1;
		check_value("ov", ov, 1'b0);
	endtask

	// outputs settle after the rising edge, so they are read on the falling one
	always @(negedge clock) begin
		if (!rst && ov) begin
			if (exp_data.size() == 0) begin
				stop_on_error($sformatf("ov went high at cycle %0d with no block in flight",
					cycle));
			end else begin
				check_value("ciphertext", ciphertext, exp_data.pop_front());
				check_value("ov cycle", cycle, exp_cycle.pop_front());
				ov_count++;
			end
		end
	end

	initial begin
		#(watchdog_cycles * 10);
		stop_on_error("timeout, the run did not finish in the expected time");
	end

	initial begin
		check_value("des_encrypt known answer", des_encrypt(kat_key, kat_pt), kat_ct);
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;
		key = kat_key;

		// known answer block alone in the pipeline pins down the latency
		send_block(kat_pt, kat_ct);
		drain();

		repeat (n_burst) send_random();
		drain();

		// iv high about half the time
		repeat (n_gapped) begin
			if ($random(seed) & 1) begin
				send_random();
			end else begin
				idle();
			end
		end
		drain();
		check_value("ov pulses", ov_count, iv_count);

		// the key only changes with the pipeline empty
		repeat (n_keys) begin
			@(posedge clock);
			#1;
			key = {$random(seed), $random(seed)};
			repeat (n_per_key) send_random();
			drain();
		end
		check_value("ov pulses", ov_count, iv_count);

		// reset while blocks are in flight
		repeat (n_reset) send_random();
		@(posedge clock);
		#1;
		rst = 1'b1;
		iv = 1'b0;
		@(posedge clock);
		#1;
		check_value("ov", ov, 1'b0);
		exp_data.delete();
		exp_cycle.delete();
		@(posedge clock);
		#1;
		rst = 1'b0;
		repeat (n_reset) send_random();
		drain();

		if (exp_data.size() != 0) begin
			stop_on_error($sformatf("%0d results never came back", exp_data.size()));
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

/* des.f */
logic/des_pkg.sv
logic/des_input_stage.sv
logic/des_key_schedule.sv
logic/des_round.sv
logic/des_round_pipeline.sv
logic/des_output_stage.sv
logic/des.sv
tb/des_tb.sv
